/* list.f */
+incdir+tests
hw/mem_pkg.sv
hw/mmio_decoder.sv
hw/dp_byte_ram.sv
hw/mem_rsp_gen.sv
hw/sim_mem_top.sv
tests/tb_clk_gen.sv
tests/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memory testbench with verilator
set -euo pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_top \
  -Mdir "$BUILD_DIR"

"./$BUILD_DIR/Vtb_top" | tee "$LOG_FILE"

if grep -q '\*\* FAIL \*\*' "$LOG_FILE"; then
  echo "simulation reported failures, see $LOG_FILE"
  exit 1
fi

if ! grep -q '\*\* PASS \*\*' "$LOG_FILE"; then
  echo "simulation ended without a verdict, see $LOG_FILE"
  exit 1
fi

echo "simulation clean"

/* tests/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// --------------------------------------------------
// row type
// --------------------------------------------------
typedef enum logic [2:0] {
  OP_IREAD,      // instruction fetch
  OP_DREAD,      // data read
  OP_DWRITE,     // data write to the ram
  OP_PRINT,      // console character
  OP_EXIT_VAL,   // exit with the written value
  OP_EXIT_ZERO,  // exit with zero
  OP_IRD_DWR     // fetch and data write to one word in the same cycle
} op_e;

localparam logic [3:0] F_NONE      = 4'b0000;
localparam logic [3:0] F_RND_DATA  = 4'b0001;  // data from $random
localparam logic [3:0] F_RND_STRB  = 4'b0010;  // strobes from $random
localparam logic [3:0] F_RND_ADDR  = 4'b0100;  // fresh random word in range
localparam logic [3:0] F_PREV_ADDR = 4'b1000;  // reuse the previous row's address

typedef struct packed {
  op_e        op;
  addr_t      addr;
  data_t      data;
  strb_t      strb;
  logic [3:0] flags;
} vec_t;

vec_t vec_q [$];

function automatic vec_t make_row(op_e op, addr_t addr, data_t data, strb_t strb,
                                  logic [3:0] flags);
  vec_t row;
  row.op    = op;
  row.addr  = addr;
  row.data  = data;
  row.strb  = strb;
  row.flags = flags;
  return row;
endfunction

// --------------------------------------------------
// table
// --------------------------------------------------
task automatic load_table();
  // columns: operation, byte address, data, strobes, flags
  vec_q.push_back(make_row(OP_DWRITE, 32'h0000_0040, 32'h1122_3344, 4'hF, F_NONE));
  vec_q.push_back(make_row(OP_DREAD, 32'h0000_0040, 32'h0000_0000, 4'h0, F_NONE));
  vec_q.push_back(make_row(OP_DWRITE, 32'h0000_0040, 32'hAABB_CCDD, 4'b0101, F_NONE));
  vec_q.push_back(make_row(OP_DREAD, 32'h0000_0040, 32'h0000_0000, 4'h0, F_NONE));
  vec_q.push_back(make_row(OP_DWRITE, 32'h0000_0040, 32'h9988_7766, 4'b1000, F_NONE));
  vec_q.push_back(make_row(OP_DREAD, 32'h0000_0040, 32'h0000_0000, 4'h0, F_NONE));
  vec_q.push_back(make_row(OP_IREAD, 32'h0000_0040, 32'h0000_0000, 4'h0, F_NONE));
  vec_q.push_back(make_row(OP_DWRITE, 32'h0000_0000, 32'hCAFE_F00D, 4'hF, F_NONE));
  vec_q.push_back(make_row(OP_PRINT, PRINT_ADDR, 32'h1234_5648, 4'hF, F_NONE));
  vec_q.push_back(make_row(OP_DREAD, 32'h0000_0000, 32'h0000_0000, 4'h0, F_NONE));
  vec_q.push_back(make_row(OP_DWRITE, 32'h0000_0004, 32'h5555_AAAA, 4'hF, F_NONE));
  vec_q.push_back(make_row(OP_DWRITE, 32'h0000_0010, 32'h0F0F_0F0F, 4'hF, F_NONE));
  vec_q.push_back(make_row(OP_EXIT_VAL, EXIT_VALUE_ADDR, 32'h0000_002A, 4'hF, F_NONE));
  vec_q.push_back(make_row(OP_EXIT_ZERO, EXIT_ZERO_ADDR, 32'hDEAD_BEEF, 4'hF, F_NONE));
  vec_q.push_back(make_row(OP_DREAD, 32'h0000_0004, 32'h0000_0000, 4'h0, F_NONE));
  vec_q.push_back(make_row(OP_DREAD, 32'h0000_0010, 32'h0000_0000, 4'h0, F_NONE));
  vec_q.push_back(make_row(OP_IRD_DWR, 32'h0000_0040, 32'h7654_3210, 4'hF, F_NONE));
  vec_q.push_back(make_row(OP_IREAD, 32'h0000_0040, 32'h0000_0000, 4'h0, F_NONE));
  vec_q.push_back(make_row(OP_DWRITE, 32'h0, 32'h0, 4'hF, F_RND_ADDR | F_RND_DATA));
  vec_q.push_back(make_row(OP_DREAD, 32'h0, 32'h0, 4'h0, F_PREV_ADDR));
  vec_q.push_back(make_row(OP_DWRITE, 32'h0, 32'h0, 4'h0,
                           F_PREV_ADDR | F_RND_DATA | F_RND_STRB));
  vec_q.push_back(make_row(OP_DREAD, 32'h0, 32'h0, 4'h0, F_PREV_ADDR));
  vec_q.push_back(make_row(OP_IREAD, 32'h0, 32'h0, 4'h0, F_PREV_ADDR));
endtask

`endif

/* tests/tb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_top;

  import mem_pkg::*;

  `include "tb_vectors.svh"

  localparam int RST_TIMEOUT  = 20;            // cycles allowed for reset release
  localparam int IDLE_TIMEOUT = 10;            // cycles allowed for strobes to drop
  localparam int DEPTH        = 2 ** WORD_AW;  // words in the shadow

  logic clk;
  logic arst_n;

  // dut inputs
  logic  instr_req;
  addr_t instr_addr;
  logic  data_req;
  logic  data_we;
  addr_t data_addr;
  data_t data_wdata;
  strb_t data_strb;

  // dut outputs
  logic  instr_rvalid;
  data_t instr_rdata;
  logic  data_rvalid;
  data_t data_rdata;
  logic  data_wack;
  logic  print_valid;
  char_t print_data;
  logic  exit_valid;
  data_t exit_value;

  // --------------------------------------------------
  // shadow memory and expectations
  // --------------------------------------------------
  data_t shadow [DEPTH];            // predicted ram contents
  strb_t known  [DEPTH];            // bytes written so far

  logic  exp_instr_rvalid;
  data_t exp_instr_rdata;
  data_t exp_instr_mask;            // only written bytes are compared
  logic  exp_data_rvalid;
  data_t exp_data_rdata;
  data_t exp_data_mask;
  logic  exp_data_wack;
  logic  exp_print_valid;
  char_t exp_print_data;
  logic  exp_exit_valid;
  data_t exp_exit_value;

  integer seed;                     // $random state
  addr_t  last_addr;                // address of the previous row
  int     errors;
  int     checks;
  logic   run_ok;

  tb_clk_gen u_clk (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  sim_mem_top u_dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .data_req_i     (data_req),
    .data_we_i      (data_we),
    .data_addr_i    (data_addr),
    .data_wdata_i   (data_wdata),
    .data_strb_i    (data_strb),
    .data_rvalid_o  (data_rvalid),
    .data_rdata_o   (data_rdata),
    .data_wack_o    (data_wack),
    .print_valid_o  (print_valid),
    .print_data_o   (print_data),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value)
  );

  // --------------------------------------------------
  // model helpers
  // --------------------------------------------------
  function automatic data_t lane_mask(strb_t strb);
    data_t mask;
    mask = '0;
    for (int lane = 0; lane < BYTES; lane++) begin
      if (strb[lane]) mask[lane*8 +: 8] = 8'hFF;
    end
    return mask;
  endfunction

  function automatic word_addr_t word_index(addr_t addr);
    return addr[2 +: WORD_AW];  // byte offset dropped, upper bits ignored
  endfunction

  task automatic write_shadow(input word_addr_t idx, input data_t data, input strb_t strb);
    for (int lane = 0; lane < BYTES; lane++) begin
      if (strb[lane]) begin
        shadow[idx][lane*8 +: 8] = data[lane*8 +: 8];
        known[idx][lane]         = 1'b1;
      end
    end
  endtask

  task automatic drive_idle();
    instr_req  = 1'b0;
    instr_addr = '0;
    data_req   = 1'b0;
    data_we    = 1'b0;
    data_addr  = '0;
    data_wdata = '0;
    data_strb  = '0;
  endtask

  task automatic clear_expected();
    exp_instr_rvalid = 1'b0;
    exp_instr_rdata  = '0;
    exp_instr_mask   = '0;
    exp_data_rvalid  = 1'b0;
    exp_data_rdata   = '0;
    exp_data_mask    = '0;
    exp_data_wack    = 1'b0;
    exp_print_valid  = 1'b0;
    exp_print_data   = '0;
    exp_exit_valid   = 1'b0;
    exp_exit_value   = '0;
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic drive_row(input vec_t row);
    addr_t       addr;
    data_t       data;
    strb_t       strb;
    word_addr_t  idx;
    logic [31:0] rnd;
    addr = row.addr;
    data = row.data;
    strb = row.strb;
    if ((row.flags & F_RND_ADDR) != 4'b0) begin
      rnd  = $random(seed);
      addr = {{(ADDR_W-WORD_AW-2){1'b0}}, rnd[WORD_AW-1:0], 2'b00};  // stays in the array
    end else if ((row.flags & F_PREV_ADDR) != 4'b0) begin
      addr = last_addr;
    end
    if ((row.flags & F_RND_DATA) != 4'b0) data = $random(seed);
    if ((row.flags & F_RND_STRB) != 4'b0) begin
      rnd  = $random(seed);
      strb = rnd[BYTES-1:0];
    end
    last_addr = addr;
    idx       = word_index(addr);
    drive_idle();
    clear_expected();
    // fetch prediction taken before any write of this cycle, ram is read-first
    if (row.op == OP_IREAD || row.op == OP_IRD_DWR) begin
      instr_req        = 1'b1;
      instr_addr       = addr;
      exp_instr_rvalid = 1'b1;
      exp_instr_rdata  = shadow[idx];
      exp_instr_mask   = lane_mask(known[idx]);
    end
    if (row.op == OP_DREAD) begin
      data_req        = 1'b1;
      data_addr       = addr;
      exp_data_rvalid = 1'b1;
      exp_data_rdata  = shadow[idx];
      exp_data_mask   = lane_mask(known[idx]);
    end
    if (row.op inside {OP_DWRITE, OP_IRD_DWR, OP_PRINT, OP_EXIT_VAL, OP_EXIT_ZERO}) begin
      data_req      = 1'b1;
      data_we       = 1'b1;
      data_addr     = addr;
      data_wdata    = data;
      data_strb     = strb;
      exp_data_wack = 1'b1;  // every write is acked, mmio included
    end
    case (row.op)
      OP_DWRITE, OP_IRD_DWR: write_shadow(idx, data, strb);
      OP_PRINT: begin
        exp_print_valid = 1'b1;
        exp_print_data  = data[7:0];  // ram left alone
      end
      OP_EXIT_VAL: begin
        exp_exit_valid = 1'b1;
        exp_exit_value = data;
      end
      OP_EXIT_ZERO: begin
        exp_exit_valid = 1'b1;
        exp_exit_value = '0;  // write data ignored
      end
      default: ;
    endcase
  endtask

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error: %0t ns, %s expected %b, got %b", $time, name, exp, got);
    end
  endtask

  task automatic check_word(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error: %0t ns, %s expected %08h, got %08h", $time, name, exp, got);
    end
  endtask

  // responses of the previous row, stable between the rising edges
  task automatic check_responses();
    check_bit("instr_rvalid_o", instr_rvalid, exp_instr_rvalid);
    if (exp_instr_rvalid) begin
      check_word("instr_rdata_o", instr_rdata & exp_instr_mask, exp_instr_rdata & exp_instr_mask);
    end
    check_bit("data_rvalid_o", data_rvalid, exp_data_rvalid);
    if (exp_data_rvalid) begin
      check_word("data_rdata_o", data_rdata & exp_data_mask, exp_data_rdata & exp_data_mask);
    end
    check_bit("data_wack_o", data_wack, exp_data_wack);
    check_bit("print_valid_o", print_valid, exp_print_valid);
    if (exp_print_valid) begin
      check_word("print_data_o", {24'h0, print_data}, {24'h0, exp_print_data});
    end
    check_bit("exit_valid_o", exit_valid, exp_exit_valid);
    if (exp_exit_valid) check_word("exit_value_o", exit_value, exp_exit_value);
  endtask

  // --------------------------------------------------
  // waits
  // --------------------------------------------------
  task automatic wait_reset(output logic ok);
    int cycles;
    cycles = 0;
    while (arst_n !== 1'b1 && cycles < RST_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    ok = (arst_n === 1'b1);
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((instr_rvalid || data_rvalid || data_wack || print_valid || exit_valid)
           && cycles < IDLE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= IDLE_TIMEOUT) begin
      errors++;
      $display("response strobes stayed active for %0d cycles after the last request",
               IDLE_TIMEOUT);
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    seed      = 32'h71ed34e0;
    errors    = 0;
    checks    = 0;
    last_addr = '0;
    drive_idle();                  // inputs defined from time zero
    clear_expected();
    for (int w = 0; w < DEPTH; w++) begin
      shadow[w] = '0;
      known[w]  = '0;
    end
    load_table();
    wait_reset(run_ok);
    if (!run_ok) begin
      errors++;
      $display("reset was not released within %0d cycles", RST_TIMEOUT);
    end else begin
      check_responses();           // all strobes low out of reset
      for (int i = 0; i < vec_q.size(); i++) begin
        @(negedge clk);
        check_responses();
        drive_row(vec_q[i]);
      end
      @(negedge clk);
      check_responses();           // last row
      drive_idle();
      clear_expected();
      wait_idle();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_top

`default_nettype wire

/* tests/tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD = 5;  // 10 ns clock
  localparam int RST_CYCLES  = 3;  // rising edges held in reset

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 arst_n_o = 1'b1;  // release clear of both clock edges
  end

endmodule : tb_clk_gen

`default_nettype wire

/* hw/sim_mem_top.sv */
`timescale 1ns/100ps
`default_nettype none

module sim_mem_top (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // --------------------------------------------------
  // instruction port
  // --------------------------------------------------
  input  logic           instr_req_i,
  input  mem_pkg::addr_t instr_addr_i,
  output logic           instr_rvalid_o,
  output mem_pkg::data_t instr_rdata_o,
  // --------------------------------------------------
  // data port
  // --------------------------------------------------
  input  logic           data_req_i,
  input  logic           data_we_i,
  input  mem_pkg::addr_t data_addr_i,
  input  mem_pkg::data_t data_wdata_i,
  input  mem_pkg::strb_t data_strb_i,
  output logic           data_rvalid_o,
  output mem_pkg::data_t data_rdata_o,
  output logic           data_wack_o,
  // --------------------------------------------------
  // simulation status
  // --------------------------------------------------
  output logic           print_valid_o,
  output mem_pkg::char_t print_data_o,
  output logic           exit_valid_o,
  output mem_pkg::data_t exit_value_o
);

  import mem_pkg::*;

  word_addr_t instr_word_addr;  // port a index

  // decoder to ram port b
  logic       ram_req;
  logic       ram_we;
  word_addr_t ram_addr;
  data_t      ram_wdata;
  strb_t      ram_strb;

  assign instr_word_addr = instr_addr_i[2 +: WORD_AW];  // upper bits ignored

  // --------------------------------------------------
  // data path steering
  // --------------------------------------------------
  mmio_decoder u_decoder (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (data_req_i),
    .we_i          (data_we_i),
    .addr_i        (data_addr_i),
    .wdata_i       (data_wdata_i),
    .strb_i        (data_strb_i),
    .ram_req_o     (ram_req),
    .ram_we_o      (ram_we),
    .ram_addr_o    (ram_addr),
    .ram_wdata_o   (ram_wdata),
    .ram_strb_o    (ram_strb),
    .print_valid_o (print_valid_o),
    .print_data_o  (print_data_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  // --------------------------------------------------
  // shared array
  // --------------------------------------------------
  dp_byte_ram u_ram (
    .clk_i     (clk_i),
    .a_req_i   (instr_req_i),   // fetch goes straight to port a
    .a_addr_i  (instr_word_addr),
    .a_rdata_o (instr_rdata_o),
    .b_req_i   (ram_req),
    .b_we_i    (ram_we),
    .b_addr_i  (ram_addr),
    .b_wdata_i (ram_wdata),
    .b_strb_i  (ram_strb),
    .b_rdata_o (data_rdata_o)
  );

  // --------------------------------------------------
  // response strobes
  // --------------------------------------------------
  mem_rsp_gen u_rsp (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .instr_req_i    (instr_req_i),
    .data_req_i     (data_req_i),  // raw strobe so mmio writes get acked too
    .data_we_i      (data_we_i),
    .instr_rvalid_o (instr_rvalid_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_wack_o    (data_wack_o)
  );

  // status pulses from the decoder must coincide with the write ack
  a_status_acked : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (print_valid_o || exit_valid_o) |-> data_wack_o
  ) else $error("mmio status without write ack");

endmodule : sim_mem_top

`default_nettype wire

/* hw/mem_rsp_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_rsp_gen (
  input  logic clk_i,
  input  logic arst_n_i,
  // request strobes
  input  logic instr_req_i,
  input  logic data_req_i,
  input  logic data_we_i,
  // response strobes
  output logic instr_rvalid_o,
  output logic data_rvalid_o,
  output logic data_wack_o
);

  logic data_rd_req;  // data port read this cycle
  logic data_wr_req;  // data port write this cycle, ram or mmio

  // --------------------------------------------------
  // classify
  // --------------------------------------------------
  assign data_rd_req = data_req_i & ~data_we_i;
  assign data_wr_req = data_req_i &  data_we_i;

  // --------------------------------------------------
  // one cycle delay
  // --------------------------------------------------
  // matches the ram read latency so rvalid lands with rdata
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_rvalid_o <= 1'b0;
      data_rvalid_o  <= 1'b0;
      data_wack_o    <= 1'b0;
    end else begin
      instr_rvalid_o <= instr_req_i;   // fetch never writes
      data_rvalid_o  <= data_rd_req;
      data_wack_o    <= data_wr_req;   // acks mmio writes as well
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  a_rsp_onehot : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !(data_rvalid_o && data_wack_o)
  ) else $error("read data and write ack raised together");

endmodule : mem_rsp_gen

`default_nettype wire

/* hw/dp_byte_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module dp_byte_ram (
  input  logic                clk_i,
  // port a, read only
  input  logic                a_req_i,
  input  mem_pkg::word_addr_t a_addr_i,
  output mem_pkg::data_t      a_rdata_o,
  // port b, read and byte write
  input  logic                b_req_i,
  input  logic                b_we_i,
  input  mem_pkg::word_addr_t b_addr_i,
  input  mem_pkg::data_t      b_wdata_i,
  input  mem_pkg::strb_t      b_strb_i,
  output mem_pkg::data_t      b_rdata_o
);

  import mem_pkg::*;

  localparam int LANE_W = DATA_W / BYTES;  // bits per byte lane
  localparam int DEPTH  = 2 ** WORD_AW;    // words in the array

  data_t mem [DEPTH];  // contents are undefined after power up

  // --------------------------------------------------
  // port a
  // --------------------------------------------------
  // instruction fetch path, registered output
  always_ff @(posedge clk_i) begin
    if (a_req_i) begin
      a_rdata_o <= mem[a_addr_i];  // sees the value before any same-cycle write
    end
  end

  // --------------------------------------------------
  // port b
  // --------------------------------------------------
  // read-first on this port too, a write returns the old word
  always_ff @(posedge clk_i) begin
    if (b_req_i) begin
      b_rdata_o <= mem[b_addr_i];
    end
  end

  // byte-lane write, disabled lanes keep their old contents
  always_ff @(posedge clk_i) begin
    if (b_req_i && b_we_i) begin
      for (int lane = 0; lane < BYTES; lane++) begin
        if (b_strb_i[lane]) begin
          mem[b_addr_i][lane*LANE_W +: LANE_W] <= b_wdata_i[lane*LANE_W +: LANE_W];
        end
      end
    end
  end

endmodule : dp_byte_ram

`default_nettype wire

/* hw/mmio_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module mmio_decoder (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // data port request
  input  logic                req_i,
  input  logic                we_i,
  input  mem_pkg::addr_t      addr_i,
  input  mem_pkg::data_t      wdata_i,
  input  mem_pkg::strb_t      strb_i,
  // ram port b
  output logic                ram_req_o,
  output logic                ram_we_o,
  output mem_pkg::word_addr_t ram_addr_o,
  output mem_pkg::data_t      ram_wdata_o,
  output mem_pkg::strb_t      ram_strb_o,
  // status
  output logic                print_valid_o,
  output mem_pkg::char_t      print_data_o,
  output logic                exit_valid_o,
  output mem_pkg::data_t      exit_value_o
);

  import mem_pkg::*;

  logic wr_req;         // write strobe on the data port
  logic print_hit;      // write to the console address
  logic exit_val_hit;   // write to the exit-with-value address
  logic exit_zero_hit;  // write to the exit-with-zero address
  logic mmio_hit;       // any of the above

  // --------------------------------------------------
  // address match
  // --------------------------------------------------
  // only writes are decoded, reads of these addresses fall through to the ram
  assign wr_req        = req_i & we_i;
  assign print_hit     = wr_req & (addr_i == PRINT_ADDR);
  assign exit_val_hit  = wr_req & (addr_i == EXIT_VALUE_ADDR);
  assign exit_zero_hit = wr_req & (addr_i == EXIT_ZERO_ADDR);
  assign mmio_hit      = print_hit | exit_val_hit | exit_zero_hit;

  // --------------------------------------------------
  // ram side, same cycle
  // --------------------------------------------------
  assign ram_req_o   = req_i & ~mmio_hit;          // mmio writes never reach the array
  assign ram_we_o    = we_i;
  assign ram_addr_o  = addr_i[2 +: WORD_AW];       // drop the byte offset
  assign ram_wdata_o = wdata_i;
  assign ram_strb_o  = strb_i;

  // --------------------------------------------------
  // status strobes, one cycle after the write
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      print_valid_o <= 1'b0;
      exit_valid_o  <= 1'b0;
    end else begin
      print_valid_o <= print_hit;                     // single cycle pulse
      exit_valid_o  <= exit_val_hit | exit_zero_hit;  // both exit kinds share one strobe
    end
  end

  // payload only loads on a hit, so it stays put between strobes
  always_ff @(posedge clk_i) begin
    if (print_hit) begin
      print_data_o <= wdata_i[$bits(char_t)-1:0];  // low byte is the character
    end
    if (exit_val_hit) begin
      exit_value_o <= wdata_i;
    end else if (exit_zero_hit) begin
      exit_value_o <= '0;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // the array only covers the low word range, anything above would alias
  a_ram_in_bounds : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ram_req_o |-> (addr_i[ADDR_W-1:WORD_AW+2] == '0)
  ) else $error("data access out of ram bounds, addr %08h", addr_i);

endmodule : mmio_decoder

`default_nettype wire

/* hw/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int ADDR_W  = 32;              // byte address width
  localparam int DATA_W  = 32;              // data word width
  localparam int BYTES   = DATA_W / 8;      // byte lanes per word
  localparam int WORD_AW = 10;              // ram word index width, 1024 words

  // --------------------------------------------------
  // types
  // --------------------------------------------------
  typedef logic [ADDR_W-1:0]  addr_t;       // byte address
  typedef logic [DATA_W-1:0]  data_t;       // data word
  typedef logic [BYTES-1:0]   strb_t;       // one enable per byte lane
  typedef logic [WORD_AW-1:0] word_addr_t;  // ram word index
  typedef logic [7:0]         char_t;       // print character

  // --------------------------------------------------
  // mmio map, write side only
  // --------------------------------------------------
  localparam addr_t PRINT_ADDR      = 32'h1000_0000;  // low byte goes to the console
  localparam addr_t EXIT_VALUE_ADDR = 32'h2000_0004;  // exit with the written value
  localparam addr_t EXIT_ZERO_ADDR  = 32'h2000_0010;  // exit with code zero

endpackage : mem_pkg

`default_nettype wire
